/* Bender.yml */
package:
  name: dwnld

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dwnld_pkg.sv
      - dwnld_stage_if.sv
      - dwnld_region_decode.sv
      - dwnld_pixel_xform.sv
      - dwnld_prog_writer.sv
      - dwnld_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_dwnld.sv

/* dwnld_macros.svh */
// Memory map of the download stream
// Region starts are byte offsets in the stream, and the main CPU starts at 0
// The region order is fixed: main, sound, scroll, objects, PCM, then the PROMs
// Bytes at or above the PROM start never reach SDRAM

`ifndef DWNLD_MACROS_SVH
`define DWNLD_MACROS_SVH

// Address widths, SDRAM word address and host byte address
`define DWNLD_AW        22
`define DWNLD_IOCTL_AW  25

// SDRAM region starts
`define DWNLD_SND_START 22'h01_0000
`define DWNLD_SCR_START 22'h01_2000
`define DWNLD_OBJ_START 22'h01_6000
`define DWNLD_PCM_START 22'h01_E000

// First byte sent to the colour PROMs
`define DWNLD_PROM_START 25'h02_E000

`endif

/* dwnld_pixel_xform.sv */
// Second pipeline stage, holds one item
// Scroll and object bytes get their two pixel nibbles swapped
// All other regions pass the byte through as it came in

`default_nettype none
`timescale 1ns/10ps

module dwnld_pixel_xform (
    input  logic          clk,
    input  logic          arst_n,
    dwnld_stage_if.sink   in_if,
    dwnld_stage_if.source out_if
);
    import dwnld_pkg::*;

    dwnld_byte_u xf_byte;
    logic        take;

    assign in_if.ready = !out_if.valid || out_if.ready;
    assign take        = in_if.valid && in_if.ready;

    always_comb begin
        if (in_if.region == REG_SCR || in_if.region == REG_OBJ) begin
            xf_byte.pix.pix_hi = in_if.data.pix.pix_lo;
            xf_byte.pix.pix_lo = in_if.data.pix.pix_hi;
        end else begin
            xf_byte.raw = in_if.data.raw;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_if.valid <= 1'b0;
        end else if (in_if.ready) begin
            out_if.valid <= in_if.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_if.region <= in_if.region;
            out_if.addr   <= in_if.addr;
            out_if.mask   <= in_if.mask;
            out_if.data   <= xf_byte;
        end
    end

    // Writer may stall for many cycles on the SDRAM acknowledge
    hold_while_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        out_if.valid && !out_if.ready |=> out_if.valid
            && $stable({out_if.region, out_if.addr, out_if.mask, out_if.data}))
        else $error("s_xf item changed while stalled");

endmodule

`default_nettype wire

/* dwnld_pkg.sv */
// Types shared by the ROM download pipeline stages
// Region codes are 3 bits wide, and the order of the literals is not significant
// A byte is read raw for code and samples, or as two 4-bit pixels for graphics

`default_nettype none

package dwnld_pkg;

    // Destination of each downloaded byte
    typedef enum logic [2:0] {
        REG_MAIN,
        REG_SND,
        REG_SCR,
        REG_OBJ,
        REG_PCM,
        REG_PROM
    } dwnld_region_e;

    // Two packed pixels, high nibble first
    typedef struct packed {
        logic [3:0] pix_hi;
        logic [3:0] pix_lo;
    } dwnld_pix_t;

    // Same 8 bits decoded as a plain byte or as a pixel pair
    typedef union packed {
        logic [7:0] raw;
        dwnld_pix_t pix;
    } dwnld_byte_u;

endpackage

`default_nettype wire

/* dwnld_prog_writer.sv */
// Last pipeline stage that drives the SDRAM program port and the PROM strobe
// prog_we stays high with a fixed payload until sdram_ack is sampled high
// prom_we is a single-cycle strobe with no acknowledge
// A new item is taken only when idle

`default_nettype none
`timescale 1ns/10ps

`include "dwnld_macros.svh"

module dwnld_prog_writer (
    input  logic                 clk,
    input  logic                 arst_n,
    dwnld_stage_if.sink          in_if,
    input  logic                 sdram_ack,
    output logic [`DWNLD_AW-1:0] prog_addr,
    output logic [7:0]           prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    output logic                 prom_we
);
    import dwnld_pkg::*;

    // FSM states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ACK  = 2'd1;
    localparam logic [1:0] ST_PROM = 2'd2;

    logic [1:0] state;
    logic       take;

    assign in_if.ready = (state == ST_IDLE);
    assign take        = in_if.valid && in_if.ready;

    // Strobes come straight from the state register
    assign prog_we = (state == ST_ACK);
    assign prom_we = (state == ST_PROM);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state <= (in_if.region == REG_PROM) ? ST_PROM : ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (sdram_ack) begin
                        state <= ST_IDLE;
                    end
                end
                ST_PROM: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            prog_addr <= in_if.addr;
            prog_data <= in_if.data.raw;
            prog_mask <= in_if.mask;
        end
    end

    we_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(prog_we && prom_we))
        else $error("prog_we and prom_we high together");

endmodule

`default_nettype wire

/* dwnld_region_decode.sv */
// First pipeline stage, takes host bytes and classifies them by address
// A byte is taken when ioctl_wr is high while downloading is high
// The host must keep ioctl_wr low while wr_busy is high, or the byte is lost
// SDRAM bytes get a word address and one lane, PROM bytes a relative address

`default_nettype none
`timescale 1ns/10ps

`include "dwnld_macros.svh"

module dwnld_region_decode (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       downloading,
    input  logic                       ioctl_wr,
    input  logic [`DWNLD_IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                 ioctl_dout,
    output logic                       wr_busy,
    dwnld_stage_if.source              out_if
);
    import dwnld_pkg::*;

    // Region starts widened to the host address
    localparam logic [`DWNLD_IOCTL_AW-1:0] SND_START  = `DWNLD_SND_START;
    localparam logic [`DWNLD_IOCTL_AW-1:0] SCR_START  = `DWNLD_SCR_START;
    localparam logic [`DWNLD_IOCTL_AW-1:0] OBJ_START  = `DWNLD_OBJ_START;
    localparam logic [`DWNLD_IOCTL_AW-1:0] PCM_START  = `DWNLD_PCM_START;
    localparam logic [`DWNLD_IOCTL_AW-1:0] PROM_START = `DWNLD_PROM_START;

    dwnld_region_e        dec_region;
    logic [`DWNLD_AW-1:0] dec_addr;
    logic [1:0]           dec_mask;
    logic                 byte_in;
    logic                 can_load;

    assign byte_in  = downloading && ioctl_wr;
    // Slot is free, or its item leaves on this edge
    assign can_load = !out_if.valid || out_if.ready;
    assign wr_busy  = out_if.valid && !out_if.ready;

    always_comb begin
        if (ioctl_addr >= PROM_START) begin
            dec_region = REG_PROM;
        end else if (ioctl_addr < SND_START) begin
            dec_region = REG_MAIN;
        end else if (ioctl_addr < SCR_START) begin
            dec_region = REG_SND;
        end else if (ioctl_addr < OBJ_START) begin
            dec_region = REG_SCR;
        end else if (ioctl_addr < PCM_START) begin
            dec_region = REG_OBJ;
        end else begin
            dec_region = REG_PCM;
        end
    end

    always_comb begin
        if (dec_region == REG_PROM) begin
            dec_addr = `DWNLD_AW'(ioctl_addr - PROM_START);
            dec_mask = 2'b11;
        end else begin
            // 16-bit SDRAM words, even bytes go in the low lane
            dec_addr = ioctl_addr[`DWNLD_AW:1];
            dec_mask = ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_if.valid <= 1'b0;
        end else if (can_load) begin
            out_if.valid <= byte_in;
        end
    end

    always_ff @(posedge clk) begin
        if (can_load && byte_in) begin
            out_if.region   <= dec_region;
            out_if.addr     <= dec_addr;
            out_if.mask     <= dec_mask;
            out_if.data.raw <= ioctl_dout;
        end
    end

    // Host flow control across the module boundary
    host_respects_busy: assert property (@(posedge clk) disable iff (!arst_n)
        byte_in |-> !wr_busy)
        else $error("host write while wr_busy is high");

    region_known: assert property (@(posedge clk) disable iff (!arst_n)
        out_if.valid |-> !$isunknown(out_if.region))
        else $error("unknown region on decoded item");

endmodule

`default_nettype wire

/* dwnld_stage_if.sv */
// One decoded download byte passed between pipeline stages
// An item moves on a rising edge where valid and ready are both high
// The source keeps valid and the payload steady until the item moves
// The mask is active low, one bit per SDRAM byte lane

`default_nettype none
`timescale 1ns/10ps

`include "dwnld_macros.svh"

interface dwnld_stage_if;
    import dwnld_pkg::*;

    logic                 valid;
    logic                 ready;
    dwnld_region_e        region;
    logic [`DWNLD_AW-1:0] addr;
    // Active low lane enables
    logic [1:0]           mask;
    dwnld_byte_u          data;

    modport source (
        output valid,
        output region,
        output addr,
        output mask,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  region,
        input  addr,
        input  mask,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

/* dwnld_top.sv */
// ROM download path from the host byte stream to SDRAM and PROM writes
// Three stages: region decode, pixel transform, program writer
// Up to three bytes in flight, and they leave in arrival order
// The host must hold ioctl_wr low while wr_busy is high

`default_nettype none
`timescale 1ns/10ps

`include "dwnld_macros.svh"

module dwnld_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       downloading,
    input  logic [`DWNLD_IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                 ioctl_dout,
    input  logic                       ioctl_wr,
    input  logic                       sdram_ack,
    output logic                       wr_busy,
    output logic [`DWNLD_AW-1:0]       prog_addr,
    output logic [7:0]                 prog_data,
    output logic [1:0]                 prog_mask,
    output logic                       prog_we,
    output logic                       prom_we
);

    // Decode to transform, and transform to writer
    dwnld_stage_if s_dec ();
    dwnld_stage_if s_xf ();

    dwnld_region_decode u_decode (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .wr_busy     ( wr_busy     ),
        .out_if      ( s_dec       )
    );

    dwnld_pixel_xform u_xform (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .in_if  ( s_dec  ),
        .out_if ( s_xf   )
    );

    dwnld_prog_writer u_writer (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .in_if     ( s_xf      ),
        .sdram_ack ( sdram_ack ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_mask ( prog_mask ),
        .prog_we   ( prog_we   ),
        .prom_we   ( prom_we   )
    );

endmodule

`default_nettype wire

/* list.f */
+incdir+.
dwnld_pkg.sv
dwnld_stage_if.sv
dwnld_region_decode.sv
dwnld_pixel_xform.sv
dwnld_prog_writer.sv
dwnld_top.sv
tb_dwnld.sv

/* tb_dwnld.sv */
// Testbench for dwnld_top with a random host byte stream from a fixed seed
// Expected writes come from a model of the address, mask and data rules
// The SDRAM responder takes each write's ack delay from the model queue
// Host inputs and sdram_ack change 1 ns after the rising clock edge

`default_nettype none
`timescale 1ns/10ps

`include "dwnld_macros.svh"

module tb_dwnld;

    localparam integer N_SWEEP = 12;
    localparam integer N_FAST = 40;
    localparam integer N_SLOW = 40;
    localparam integer N_MIX = 150;
    localparam integer N_IDLE = 10;
    localparam integer N_TOTAL = N_SWEEP + N_FAST + N_SLOW + N_MIX + N_IDLE;
    localparam integer TIMEOUT_CYCLES = N_TOTAL * 20 + 200;

    localparam logic [24:0] SND_START = `DWNLD_SND_START;
    localparam logic [24:0] SCR_START = `DWNLD_SCR_START;
    localparam logic [24:0] OBJ_START = `DWNLD_OBJ_START;
    localparam logic [24:0] PCM_START = `DWNLD_PCM_START;
    localparam logic [24:0] PROM_START = `DWNLD_PROM_START;

    typedef struct packed {
        logic        prom;
        logic [21:0] addr;
        logic [7:0]  data;
        logic [1:0]  mask;
        logic [2:0]  ack_delay;
    } exp_write_t;

    logic        clk;
    logic        arst_n;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;
    logic        sdram_ack;
    logic        wr_busy;
    logic [21:0] prog_addr;
    logic [7:0]  prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;
    logic        prom_we;

    exp_write_t  exp_q[$];
    integer      seed = 32'ha086_0944;
    integer      value_errors = 0;
    integer      other_errors = 0;
    integer      writes_checked = 0;
    integer      cycle = 0;
    integer      last_drive_cycle = 0;
    integer      first_drive_cycle = 0;
    integer      ack_min = 0;
    integer      ack_span = 7;
    integer      ack_wait = 0;
    logic        ack_pending = 1'b0;
    logic        latency_armed = 1'b0;
    logic        busy_seen = 1'b0;
    logic        prev_strobe = 1'b0;
    logic        prev_prog_we = 1'b0;
    logic [31:0] held_payload = '0;

    dwnld_top dwnld_top_inst (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .wr_busy     ( wr_busy     ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    // Reference model of one byte
    function automatic exp_write_t expected_write(input logic [24:0] a, input logic [7:0] d);
        exp_write_t e;
        logic       gfx;
        e.prom = (a >= PROM_START);
        gfx = (a >= SCR_START) && (a < PCM_START);
        if (e.prom) begin
            e.addr = 22'(a - PROM_START);
            e.mask = 2'b11;
        end else begin
            // Even bytes enable the low lane
            e.addr = 22'(a >> 1);
            e.mask = (a % 2 == 0) ? 2'b10 : 2'b01;
        end
        e.data = gfx ? {d[3:0], d[7:4]} : d;
        e.ack_delay = 3'd0;
        return e;
    endfunction

    // Mostly near a region start and sometimes anywhere
    function automatic logic [24:0] pick_addr();
        integer      sel;
        integer      offs;
        logic [24:0] base;
        sel = $unsigned($random(seed)) % 8;
        case (sel)
            0: base = 25'd0;
            1: base = SND_START;
            2: base = SCR_START;
            3: base = OBJ_START;
            4: base = PCM_START;
            5: base = PROM_START;
            default: base = $unsigned($random(seed)) % (PROM_START + 256);
        endcase
        offs = ($unsigned($random(seed)) % 16) - 8;
        if (sel > 5 || (offs < 0 && base < -offs)) begin
            return base;
        end
        return base + offs;
    endfunction

    // Random byte whose two nibbles differ so a swap always shows
    function automatic logic [7:0] random_pixel_pair();
        logic [7:0] d;
        d = 8'($random(seed));
        d[3:0] = ~d[7:4];
        return d;
    endfunction

    // Called and returns 1 ns after an edge
    task automatic drive_byte(input logic [24:0] addr, input logic [7:0] data, input integer gap);
        exp_write_t e;
        while (wr_busy) begin
            @(posedge clk);
            #1;
        end
        ioctl_addr = addr;
        ioctl_dout = data;
        ioctl_wr = 1'b1;
        last_drive_cycle = cycle;
        if (downloading) begin
            e = expected_write(addr, data);
            e.ack_delay = 3'(ack_min + $unsigned($random(seed)) % ack_span);
            exp_q.push_back(e);
        end
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_random(input integer count, input integer gap_max);
        integer gap;
        for (int i = 0; i < count; i++) begin
            gap = (gap_max == 0) ? 0 : $unsigned($random(seed)) % (gap_max + 1);
            drive_byte(pick_addr(), 8'($random(seed)), gap);
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (4) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_write(input logic is_prom);
        exp_write_t e;
        assert (exp_q.size() != 0) else begin
            $display("Write seen at %0t ns with no host byte pending", $time);
            other_errors++;
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            assert (e.prom == is_prom) else begin
                $display("Wrong port at %0t ns, PROM byte expected: %0b", $time, e.prom);
                other_errors++;
            end
            check_value("prog_addr", 32'(e.addr), 32'(prog_addr));
            check_value("prog_data", 32'(e.data), 32'(prog_data));
            check_value("prog_mask", 32'(e.mask), 32'(prog_mask));
            writes_checked++;
        end
    endtask

    // Monitor sees the values held just before each edge
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (arst_n) begin
            if (wr_busy) begin
                busy_seen = 1'b1;
            end
            if ((prog_we || prom_we) && !prev_strobe && latency_armed) begin
                check_value("ioctl_wr to strobe cycles", 32'd3, 32'(cycle - 1 - first_drive_cycle));
                latency_armed = 1'b0;
            end
            if (prog_we) begin
                if (prev_prog_we) begin
                    check_value("held prog payload", held_payload, {prog_addr, prog_data, prog_mask});
                end
                held_payload = {prog_addr, prog_data, prog_mask};
            end
            if ((prog_we && sdram_ack) || prom_we) begin
                check_write(prom_we);
            end
        end
        prev_strobe = prog_we || prom_we;
        prev_prog_we = prog_we;
    end

    // SDRAM acknowledge after the delay stored with the front write
    initial begin
        sdram_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!prog_we) begin
                sdram_ack = 1'b0;
                ack_pending = 1'b0;
            end else begin
                if (!ack_pending) begin
                    ack_pending = 1'b1;
                    ack_wait = (exp_q.size() != 0) ? exp_q[0].ack_delay : 0;
                end
                if (ack_wait == 0) begin
                    sdram_ack = 1'b1;
                end else begin
                    ack_wait = ack_wait - 1;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the download stalled", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [24:0] sweep_addr;
        arst_n = 1'b0;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_wr = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        check_value("prog_we", 32'd0, 32'(prog_we));
        check_value("prom_we", 32'd0, 32'(prom_we));
        check_value("wr_busy", 32'd0, 32'(wr_busy));
        arst_n = 1'b1;
        downloading = 1'b1;
        @(posedge clk);
        #1;

        // Bytes at each region start and just below it
        for (int i = 0; i < N_SWEEP / 2; i++) begin
            case (i)
                0: sweep_addr = 25'd1;
                1: sweep_addr = SND_START;
                2: sweep_addr = SCR_START;
                3: sweep_addr = OBJ_START;
                4: sweep_addr = PCM_START;
                default: sweep_addr = PROM_START;
            endcase
            drive_byte(sweep_addr, random_pixel_pair(), 1);
            drive_byte(sweep_addr - 25'd1, random_pixel_pair(), 0);
        end
        wait_drained();

        // Back-to-back bytes with immediate acks and a timed first strobe
        ack_min = 0;
        ack_span = 1;
        drive_byte(pick_addr(), 8'($random(seed)), 0);
        first_drive_cycle = last_drive_cycle;
        latency_armed = 1'b1;
        send_random(N_FAST - 1, 0);
        wait_drained();
        assert (!latency_armed) else begin
            $display("No strobe seen for the first byte of the back-to-back run");
            other_errors++;
        end

        // Long acks must back up the pipeline
        ack_min = 4;
        ack_span = 3;
        busy_seen = 1'b0;
        send_random(N_SLOW, 0);
        wait_drained();
        assert (busy_seen) else begin
            $display("wr_busy never rose during long SDRAM acknowledge delays");
            other_errors++;
        end

        ack_min = 0;
        ack_span = 7;
        send_random(N_MIX, 3);
        wait_drained();

        // Host writes outside a download are ignored
        downloading = 1'b0;
        send_random(N_IDLE, 1);
        repeat (20) @(posedge clk);
        assert (exp_q.size() == 0) else begin
            $display("%0d expected writes never left the DUT", exp_q.size());
            other_errors++;
        end

        $display("Errors: %0d value, %0d other, %0d writes checked",
                 value_errors, other_errors, writes_checked);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
